// File: verilog/fast_cmd_pkg.sv
//////////////////////////////
// Fast command receiver package
// Symbol width, lock threshold and command codes
//////////////////////////////
`default_nettype none

package fast_cmd_pkg;

	//////////////////////////////
	// Symbol framing
	//////////////////////////////

	// Command symbol width, sent MSB first
	localparam int WORD_W = 8;

	// Consecutive IDLEs at one boundary before lock
	localparam logic [2:0] LOCK_COUNT = 3'd4;

	//////////////////////////////
	// Command codes
	//////////////////////////////

	// Filler symbol, also the alignment pattern
	localparam logic [WORD_W-1:0] CMD_IDLE = 8'hF0;
	// Link reset
	localparam logic [WORD_W-1:0] CMD_LINK_RESET = 8'h33;
	// Bunch counter reset
	localparam logic [WORD_W-1:0] CMD_BCR = 8'h5A;
	// Level-1 accept
	localparam logic [WORD_W-1:0] CMD_L1A = 8'h96;
	// Level-1 accept together with bunch counter reset
	localparam logic [WORD_W-1:0] CMD_L1A_BCR = 8'h99;
	// Charge injection
	localparam logic [WORD_W-1:0] CMD_CHARGE_INJ = 8'h69;

	// No rotation of a repeated F0 stream gives F0 off the boundary
	// so a single IDLE match already points at the true edge

endpackage

`default_nettype wire

// File: verilog/bitclkgen.sv
//////////////////////////////
// Phase clock generator
// Divides clk1280 by four into four gated
// 320 MHz phases spaced one cycle apart
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bitclkgen (
	input  logic       clk1280,
	input  logic       rstn,
	input  logic       enable,
	input  logic [3:0] clken,
	output logic [3:0] clk320,
	output logic [1:0] phase_count
);

	//////////////////////////////
	// Phase counter
	//////////////////////////////

	// Free running while enabled, holds otherwise
	always_ff @(posedge clk1280) begin
		if (!rstn) begin
			phase_count <= 2'd0;
		end else if (enable) begin
			phase_count <= phase_count + 2'd1;
		end
	end

	//////////////////////////////
	// Phase outputs
	//////////////////////////////

	// Phase k rises after count k, falls after count k+2
	// Two cycles high, two low, one cycle behind the counter
	// A low clken pulls its phase down on the next edge
	// Everything freezes while enable is low
	always_ff @(posedge clk1280) begin
		if (!rstn) begin
			clk320 <= 4'b0000;
		end else if (enable) begin
			for (int k = 0; k < 4; k++) begin
				if (!clken[k]) begin
					// Gated off
					clk320[k] <= 1'b0;
				end else if (phase_count == 2'(k)) begin
					// Rising edge of this phase
					clk320[k] <= 1'b1;
				end else if (phase_count == 2'(k + 2)) begin
					// Half period later, wraps mod 4
					clk320[k] <= 1'b0;
				end
			end
		end
	end

	// Phase map for reference
	// count 0 -> clk320[0] up, clk320[2] down
	// count 1 -> clk320[1] up, clk320[3] down
	// count 2 -> clk320[2] up, clk320[0] down
	// count 3 -> clk320[3] up, clk320[1] down
	// so clk320[k] and clk320[k+2] stay complementary once running

	// Downstream stages sample on phase_count itself,
	// not on the gated outputs, so gating one phase
	// never disturbs the bit sampler

endmodule

`default_nettype wire

// File: verilog/bit_sampler.sv
//////////////////////////////
// Bit sampler
// Takes the 320 Mb/s command line at one phase
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bit_sampler (
	input  logic       clk1280,
	input  logic       rstn,
	input  logic       enable,
	input  logic [1:0] phase_count,
	input  logic [1:0] phase_sel,
	input  logic       fcmd_in,
	output logic       bit_data,
	output logic       bit_strobe
);

	// Sampling instant within the four-cycle bit period
	logic sample_now;

	assign sample_now = enable && (phase_count == phase_sel);

	// Capture the line once per bit
	always_ff @(posedge clk1280) begin
		if (sample_now) begin
			bit_data <= fcmd_in;
		end
	end

	// One-cycle strobe alongside the captured bit
	always_ff @(posedge clk1280) begin
		if (!rstn) begin
			bit_strobe <= 1'b0;
		end else begin
			bit_strobe <= sample_now;
		end
	end

endmodule

`default_nettype wire

// File: verilog/symbol_aligner.sv
//////////////////////////////
// Symbol aligner
// Hunts for IDLE to find the word boundary,
// then strobes out whole words
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module symbol_aligner (
	input  logic                            clk1280,
	input  logic                            rstn,
	input  logic                            enable,
	input  logic                            bit_data,
	input  logic                            bit_strobe,
	output logic [fast_cmd_pkg::WORD_W-1:0] word,
	output logic                            word_strobe,
	output logic                            locked
);

	import fast_cmd_pkg::*;

	logic [WORD_W-1:0] shift_reg;
	logic [WORD_W-1:0] shift_next;
	// Bits shifted since the last boundary
	logic [2:0]        bit_pos;
	// Consecutive IDLE hits at one boundary
	logic [2:0]        match_cnt;
	logic              idle_hit;
	logic              on_boundary;

	// New bit enters at the LSB, so MSB-first words land aligned
	assign shift_next  = {shift_reg[WORD_W-2:0], bit_data};
	assign idle_hit    = (shift_next == CMD_IDLE);
	// Eighth shift since the last boundary
	assign on_boundary = (bit_pos == 3'(WORD_W - 1));
	assign word        = shift_reg;

	// Serial to parallel
	always_ff @(posedge clk1280) begin
		if (bit_strobe) begin
			shift_reg <= shift_next;
		end
	end

	//////////////////////////////
	// Hunt, lock and word strobe
	//////////////////////////////
	always_ff @(posedge clk1280) begin
		if (!rstn || !enable) begin
			bit_pos     <= 3'd0;
			match_cnt   <= 3'd0;
			locked      <= 1'b0;
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= 1'b0;
			if (bit_strobe) begin
				bit_pos <= bit_pos + 3'd1;
				if (locked) begin
					// Boundary fixed, just mark whole words
					word_strobe <= on_boundary;
				end else if (idle_hit) begin
					// Restart position at this candidate boundary
					bit_pos <= 3'd0;
					if (match_cnt != 3'd0 && on_boundary) begin
						match_cnt <= match_cnt + 3'd1;
						locked    <= (match_cnt + 3'd1 == LOCK_COUNT);
					end else begin
						match_cnt <= 3'd1;
					end
				end else if (on_boundary) begin
					// Expected IDLE missing, run broken
					match_cnt <= 3'd0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fcmd_decoder.sv
//////////////////////////////
// Fast command decoder
// Turns aligned words into one-cycle pulses
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module fcmd_decoder (
	input  logic                            clk1280,
	input  logic                            rstn,
	input  logic [fast_cmd_pkg::WORD_W-1:0] word,
	input  logic                            word_strobe,
	output logic                            idle,
	output logic                            link_reset,
	output logic                            bcr,
	output logic                            l1a,
	output logic                            charge_inj,
	output logic                            cmd_err
);

	import fast_cmd_pkg::*;

	// All pulses registered, one cycle after word_strobe
	always_ff @(posedge clk1280) begin
		if (!rstn) begin
			idle       <= 1'b0;
			link_reset <= 1'b0;
			bcr        <= 1'b0;
			l1a        <= 1'b0;
			charge_inj <= 1'b0;
			cmd_err    <= 1'b0;
		end else begin
			// Default back to quiet each cycle
			idle       <= 1'b0;
			link_reset <= 1'b0;
			bcr        <= 1'b0;
			l1a        <= 1'b0;
			charge_inj <= 1'b0;
			cmd_err    <= 1'b0;
			if (word_strobe) begin
				case (word)
					CMD_IDLE:       idle       <= 1'b1;
					CMD_LINK_RESET: link_reset <= 1'b1;
					CMD_BCR:        bcr        <= 1'b1;
					CMD_L1A:        l1a        <= 1'b1;
					// Trigger and counter reset together
					CMD_L1A_BCR: begin
						l1a <= 1'b1;
						bcr <= 1'b1;
					end
					CMD_CHARGE_INJ: charge_inj <= 1'b1;
					// Anything else is a corrupted symbol
					default:        cmd_err    <= 1'b1;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fast_cmd_rx.sv
//////////////////////////////
// Fast command receiver top
// Clock gen, sampler, aligner, decoder
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module fast_cmd_rx (
	input  logic       clk1280,
	input  logic       rstn,
	input  logic       enable,
	input  logic [3:0] clken,
	input  logic [1:0] phase_sel,
	input  logic       fcmd_in,
	output logic [3:0] clk320,
	output logic       locked,
	output logic       idle,
	output logic       link_reset,
	output logic       bcr,
	output logic       l1a,
	output logic       charge_inj,
	output logic       cmd_err
);

	import fast_cmd_pkg::*;

	// Stage to stage wires
	logic [1:0]        phase_count;
	logic              bit_data;
	logic              bit_strobe;
	logic [WORD_W-1:0] word;
	logic              word_strobe;

	//////////////////////////////
	// Pipeline
	//////////////////////////////

	bitclkgen bitclkgen_inst (
		.clk1280     (clk1280),
		.rstn        (rstn),
		.enable      (enable),
		.clken       (clken),
		.clk320      (clk320),
		.phase_count (phase_count)
	);

	bit_sampler bit_sampler_inst (
		.clk1280     (clk1280),
		.rstn        (rstn),
		.enable      (enable),
		.phase_count (phase_count),
		.phase_sel   (phase_sel),
		.fcmd_in     (fcmd_in),
		.bit_data    (bit_data),
		.bit_strobe  (bit_strobe)
	);

	symbol_aligner symbol_aligner_inst (
		.clk1280     (clk1280),
		.rstn        (rstn),
		.enable      (enable),
		.bit_data    (bit_data),
		.bit_strobe  (bit_strobe),
		.word        (word),
		.word_strobe (word_strobe),
		.locked      (locked)
	);

	fcmd_decoder fcmd_decoder_inst (
		.clk1280     (clk1280),
		.rstn        (rstn),
		.word        (word),
		.word_strobe (word_strobe),
		.idle        (idle),
		.link_reset  (link_reset),
		.bcr         (bcr),
		.l1a         (l1a),
		.charge_inj  (charge_inj),
		.cmd_err     (cmd_err)
	);

endmodule

`default_nettype wire

// File: sim/fast_cmd_rx_properties.sv
//////////////////////////////
// Receiver assertions
// Phase clock shape and pulse exclusivity
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module fast_cmd_rx_properties (
	input logic       clk1280,
	input logic       rstn,
	input logic       enable,
	input logic [3:0] clken,
	input logic [3:0] clk320,
	input logic       idle,
	input logic       link_reset,
	input logic       bcr,
	input logic       l1a,
	input logic       charge_inj,
	input logic       cmd_err
);

	// Cycles since every phase started running
	logic [3:0] run_cnt;
	logic       running;

	assign running = (run_cnt >= 4'd8);

	always_ff @(posedge clk1280) begin
		if (!rstn || !enable || clken != 4'hF) begin
			run_cnt <= 4'd0;
		end else if (run_cnt != 4'hF) begin
			run_cnt <= run_cnt + 4'd1;
		end
	end

	//////////////////////////////
	// Clock phases
	//////////////////////////////

	// Half period of two cycles
	assert property (@(posedge clk1280) disable iff (!rstn)
		running |-> clk320 == ~$past(clk320, 2))
		else $error("clk320 did not toggle two cycles apart");

	// Opposite phases stay complementary
	assert property (@(posedge clk1280) disable iff (!rstn)
		running |-> (clk320[0] != clk320[2]) && (clk320[1] != clk320[3]))
		else $error("clk320 opposite phases are equal");

	// One pulse per word, l1a with bcr counts as one
	assert property (@(posedge clk1280) disable iff (!rstn)
		$onehot0({idle, link_reset, bcr | l1a, charge_inj, cmd_err}))
		else $error("more than one command pulse active");

endmodule

bind fast_cmd_rx fast_cmd_rx_properties fast_cmd_rx_properties_inst (
	.clk1280    (clk1280),
	.rstn       (rstn),
	.enable     (enable),
	.clken      (clken),
	.clk320     (clk320),
	.idle       (idle),
	.link_reset (link_reset),
	.bcr        (bcr),
	.l1a        (l1a),
	.charge_inj (charge_inj),
	.cmd_err    (cmd_err)
);

`default_nettype wire

// File: sim/fast_cmd_rx_tb.sv
//////////////////////////////
// Fast command receiver testbench
// Directed tests of clock phases, lock,
// decoding, errors, phase select and enable
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module fast_cmd_rx_tb;

	import fast_cmd_pkg::*;

	logic       clk1280;
	logic       rstn;
	logic       enable;
	logic [3:0] clken;
	logic [1:0] phase_sel;
	logic       fcmd_in;
	logic [3:0] clk320;
	logic       locked;
	logic       idle;
	logic       link_reset;
	logic       bcr;
	logic       l1a;
	logic       charge_inj;
	logic       cmd_err;

	// Pulse order is idle, link_reset, bcr, l1a, charge_inj, cmd_err
	logic [5:0] pulse_vec;
	int         pulse_cnt [6] = '{default: 0};
	int         mark_cnt [6] = '{default: 0};
	int         prev_cnt [6] = '{default: 0};
	string      pulse_name [6] = '{"idle", "link_reset", "bcr",
		"l1a", "charge_inj", "cmd_err"};
	integer     seed = 32'h3fae;

	fast_cmd_rx fast_cmd_rx_inst (.*);

	assign pulse_vec = {cmd_err, charge_inj, l1a, bcr, link_reset, idle};

	initial begin
		clk1280 = 1'b0;
		forever #4 clk1280 = ~clk1280;
	end

	// Pulse counter, outputs settled at the falling edge
	always @(negedge clk1280) begin
		if (rstn) begin
			for (logic [2:0] j = 0; j < 3'd6; j++) begin
				if (pulse_vec[j]) begin
					pulse_cnt[j] = pulse_cnt[j] + 1;
				end
			end
		end
	end

	//////////////////////////////
	// Drivers and checking
	//////////////////////////////

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// One 320 Mb/s bit, four fast cycles
	task automatic send_bit(input logic b);
		fcmd_in = b;
		repeat (4) @(negedge clk1280);
	endtask

	task automatic send_word(input logic [7:0] code);
		logic [7:0] sr;
		sr = code;
		for (int i = 0; i < 8; i++) begin
			// Mid word, no pulse in flight
			if (i == 4) begin
				prev_cnt = mark_cnt;
				mark_cnt = pulse_cnt;
			end
			send_bit(sr[7]);
			sr = {sr[6:0], 1'b0};
		end
	endtask

	// Word then IDLE, pulses counted between the two mid points
	task automatic expect_pulses(input logic [7:0] code, input logic [5:0] mask);
		send_word(code);
		send_word(CMD_IDLE);
		for (logic [2:0] j = 0; j < 3'd6; j++) begin
			check(pulse_name[j], 32'(mark_cnt[j] - prev_cnt[j]), 32'(mask[j]));
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic verify_clock_phases();
		logic [3:0] ref_clk;
		repeat (4) @(negedge clk1280);
		// Four edges out of reset, counter went 0 to 3, phases 2 and 3 high
		ref_clk = 4'b1100;
		check("clk320", 32'(clk320), 32'(ref_clk));
		// Each phase one cycle behind the one below it
		for (int i = 0; i < 24; i++) begin
			if (i == 8) begin
				clken = 4'b1101;
			end else if (i == 16) begin
				clken = 4'hF;
			end
			@(negedge clk1280);
			ref_clk = {ref_clk[2:0], ref_clk[3]};
			// Phase 1 may take up to four cycles to rejoin
			if (i < 16 || i >= 20) begin
				check("clk320", 32'(clk320), 32'(ref_clk & clken));
			end
		end
	endtask

	// Alternating filler of random length, then IDLEs
	task automatic acquire_lock();
		int fill;
		int waited;
		fill = 1 + $unsigned($random(seed)) % 8;
		for (int i = 0; i < fill; i++) begin
			send_bit(i % 2 == 0);
		end
		for (int i = 0; i < int'(LOCK_COUNT) + 2; i++) begin
			for (int b = WORD_W - 1; b >= 0; b--) begin
				// Last bit of the fourth IDLE not yet on the line
				if (i == int'(LOCK_COUNT) - 1 && b == 0) begin
					check("locked", 32'(locked), 32'd0);
				end
				send_bit(CMD_IDLE[b]);
			end
		end
		waited = 0;
		while (!locked) begin
			if (waited == 8) begin
				$display("Timeout: locked did not rise within %0d extra IDLE words", waited);
				$display("SIMULATION FAILED");
				$fatal(1, "lock timeout");
			end
			send_word(CMD_IDLE);
			waited++;
		end
	endtask

	task automatic decode_commands();
		expect_pulses(CMD_IDLE, 6'b000001);
		expect_pulses(CMD_LINK_RESET, 6'b000010);
		expect_pulses(CMD_BCR, 6'b000100);
		expect_pulses(CMD_L1A, 6'b001000);
		expect_pulses(CMD_L1A_BCR, 6'b001100);
		expect_pulses(CMD_CHARGE_INJ, 6'b010000);
	endtask

	task automatic reject_bad_word();
		expect_pulses(8'hA5, 6'b100000);
		check("locked", 32'(locked), 32'd1);
	endtask

	task automatic rerun_at_new_phase();
		logic [3:0] frozen;
		enable = 1'b0;
		repeat (2) @(negedge clk1280);
		check("locked", 32'(locked), 32'd0);
		frozen = clk320;
		repeat (4) @(negedge clk1280);
		check("clk320", 32'(clk320), 32'(frozen));
		phase_sel = 2'd2;
		enable = 1'b1;
		acquire_lock();
		decode_commands();
		reject_bad_word();
	endtask

	initial begin
		rstn = 1'b0;
		enable = 1'b1;
		clken = 4'hF;
		phase_sel = 2'd0;
		fcmd_in = 1'b0;
		repeat (5) @(negedge clk1280);
		rstn = 1'b1;
		verify_clock_phases();
		acquire_lock();
		decode_commands();
		reject_bad_word();
		rerun_at_new_phase();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: fast_cmd_rx.f
verilog/fast_cmd_pkg.sv
verilog/bitclkgen.sv
verilog/bit_sampler.sv
verilog/symbol_aligner.sv
verilog/fcmd_decoder.sv
verilog/fast_cmd_rx.sv
sim/fast_cmd_rx_properties.sv
sim/fast_cmd_rx_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fast_cmd_rx_tb
FILELIST  ?= fast_cmd_rx.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "test failed"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
